// File: source/eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // 11-bit byte address split into block and word parts
    localparam int ADDR_W  = 11;
    localparam int BLOCK_W = 3;
    localparam int WORD_W  = 8;

    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // one bus bit slot, SCL low for the first half
    localparam int SLOT_CYCLES = 4;
    localparam int SLOT_CNT_W  = $clog2(SLOT_CYCLES);

    localparam int ACK_BIT   = 8;   // ninth slot of a byte
    localparam int BIT_CNT_W = 4;

    typedef struct packed {
        logic [3:0]         dev;
        logic [BLOCK_W-1:0] block;
        logic               rw;
    } ctrl_byte_t;

    typedef enum logic [3:0] {
        PH_IDLE,
        PH_START,
        PH_CTRL_WRITE,
        PH_ADDR_WRITE,
        PH_DATA_WRITE,
        PH_RESTART,
        PH_CTRL_READ,
        PH_DATA_READ,
        PH_MASTER_NACK,
        PH_STOP
    } engine_phase_t;

endpackage

// File: source/eeprom_req_pkg.sv
package eeprom_req_pkg;

    localparam int NUM_CLIENTS = 2;

    // queue depth equals the credits a client starts with
    localparam int REQ_CREDITS = 2;
    localparam int QPTR_W      = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
    localparam int CREDIT_W    = $clog2(REQ_CREDITS + 1);

    typedef logic [0:0] client_id_t;

    typedef struct packed {
        logic                               write;
        logic [eeprom_bus_pkg::ADDR_W-1:0]  addr;
        logic [7:0]                         data;
    } eeprom_req_t;

    // data is the byte read, or the byte written for a write
    typedef struct packed {
        client_id_t                         client;
        logic                               write;
        logic [eeprom_bus_pkg::ADDR_W-1:0]  addr;
        logic [7:0]                         data;
    } eeprom_rsp_t;

endpackage

// File: source/eeprom_arbiter.sv
`timescale 1ns/1ps
module eeprom_arbiter (
    input  logic                                     CLK,
    input  logic                                     RESET,
    input  logic [eeprom_req_pkg::NUM_CLIENTS-1:0]   req_valid,
    input  eeprom_req_pkg::eeprom_req_t              req [eeprom_req_pkg::NUM_CLIENTS],
    output logic [eeprom_req_pkg::NUM_CLIENTS-1:0]   credit_return,
    output logic                                     cmd_valid,
    output eeprom_req_pkg::eeprom_req_t              cmd,
    output eeprom_req_pkg::client_id_t               cmd_client,
    input  logic                                     cmd_ready
);
    import eeprom_req_pkg::*;

    eeprom_req_t         q_mem   [NUM_CLIENTS][REQ_CREDITS];
    logic [QPTR_W-1:0]   wr_ptr  [NUM_CLIENTS];
    logic [QPTR_W-1:0]   rd_ptr  [NUM_CLIENTS];
    logic [CREDIT_W-1:0] q_count [NUM_CLIENTS];

    client_id_t last_served;
    client_id_t sel;
    logic       found;
    logic       grant;

    function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] ptr);
        logic [QPTR_W-1:0] nxt;
        if (ptr == QPTR_W'(REQ_CREDITS - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    // round robin, search starts after the last served client
    always_comb
    begin
        int idx;
        sel   = last_served;
        found = 1'b0;
        for (int k = 1; k <= NUM_CLIENTS; k++)
        begin
            idx = (int'(last_served) + k) % NUM_CLIENTS;
            if (!found && q_count[idx] != '0)
            begin
                found = 1'b1;
                sel   = client_id_t'(idx);
            end
        end
    end

    assign cmd_valid  = found;
    assign cmd        = q_mem[sel][rd_ptr[sel]];
    assign cmd_client = sel;
    assign grant      = cmd_valid && cmd_ready;

    always_comb
    begin
        for (int i = 0; i < NUM_CLIENTS; i++)
            credit_return[i] = grant && (sel == client_id_t'(i)); // pop frees a slot
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NUM_CLIENTS; i++)
            if (req_valid[i])
                q_mem[i][wr_ptr[i]] <= req[i];
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            last_served <= client_id_t'(NUM_CLIENTS - 1); // client 0 goes first
            for (int i = 0; i < NUM_CLIENTS; i++)
            begin
                wr_ptr[i]  <= '0;
                rd_ptr[i]  <= '0;
                q_count[i] <= '0;
            end
        end
        else
        begin
            if (grant)
                last_served <= sel;
            for (int i = 0; i < NUM_CLIENTS; i++)
            begin
                if (req_valid[i])
                    wr_ptr[i] <= ptr_inc(wr_ptr[i]);
                if (credit_return[i])
                    rd_ptr[i] <= ptr_inc(rd_ptr[i]);
                case ({req_valid[i], credit_return[i]})
                    2'b10:   q_count[i] <= q_count[i] + 1'b1;
                    2'b01:   q_count[i] <= q_count[i] - 1'b1;
                    default: q_count[i] <= q_count[i];
                endcase
            end
        end
    end

endmodule

// File: source/eeprom_serial_engine.sv
`timescale 1ns/1ps
module eeprom_serial_engine (
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         cmd_valid,
    input  eeprom_req_pkg::eeprom_req_t  cmd,
    input  eeprom_req_pkg::client_id_t   cmd_client,
    output logic                         cmd_ready,
    output logic                         rsp_valid,
    output eeprom_req_pkg::eeprom_rsp_t  rsp,
    output logic                         scl,
    output logic                         sda_low,
    input  logic                         sda_in
);
    import eeprom_bus_pkg::*;
    import eeprom_req_pkg::*;

    engine_phase_t          phase;
    logic [SLOT_CNT_W-1:0]  cnt;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic [7:0]             shreg;
    logic [7:0]             rd_data;
    eeprom_req_t            cur_cmd;
    client_id_t             cur_client;
    ctrl_byte_t             ctrl;

    logic slot_end;
    logic mid_high;
    logic byte_done;
    logic slot_drive;
    logic grant;

    assign grant     = cmd_valid && cmd_ready;
    assign slot_end  = (cnt == SLOT_CNT_W'(SLOT_CYCLES - 1));
    assign mid_high  = (cnt == SLOT_CNT_W'(SLOT_CYCLES / 2)); // first cycle with SCL high
    assign byte_done = (bit_cnt == BIT_CNT_W'(ACK_BIT));

    // bus released high while idle
    assign scl = (phase == PH_IDLE) || (cnt >= SLOT_CNT_W'(SLOT_CYCLES / 2));

    always_comb
    begin
        ctrl.dev   = DEV_CODE;
        ctrl.block = cur_cmd.addr[ADDR_W-1 -: BLOCK_W];
        ctrl.rw    = (phase == PH_RESTART) ? RW_READ : RW_WRITE;
    end

    // SDA level for the SCL-low half of the slot
    always_comb
    begin
        case (phase)
            PH_CTRL_WRITE, PH_ADDR_WRITE, PH_DATA_WRITE, PH_CTRL_READ:
                slot_drive = !byte_done && !shreg[7]; // ack slot releases
            PH_STOP:
                slot_drive = 1'b1;
            default:
                slot_drive = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= PH_IDLE;
            cnt       <= '0;
            bit_cnt   <= '0;
            sda_low   <= 1'b0;
            cmd_ready <= 1'b0;
        end
        else
        begin
            cmd_ready <= 1'b0;
            if (phase == PH_IDLE)
            begin
                cnt     <= '0;
                bit_cnt <= '0;
                if (grant)
                    phase <= PH_START;
                else
                    cmd_ready <= 1'b1;
            end
            else
            begin
                cnt <= slot_end ? '0 : cnt + 1'b1;

                if (cnt == '0)
                    sda_low <= slot_drive;
                else if (mid_high &&
                         (phase == PH_START || phase == PH_RESTART || phase == PH_STOP))
                    sda_low <= (phase != PH_STOP); // SDA edge while SCL high

                if (slot_end)
                begin
                    case (phase)
                        PH_START:
                        begin
                            phase   <= PH_CTRL_WRITE;
                            bit_cnt <= '0;
                        end
                        PH_CTRL_WRITE:
                            if (byte_done)
                            begin
                                phase   <= PH_ADDR_WRITE;
                                bit_cnt <= '0;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        PH_ADDR_WRITE:
                            if (byte_done)
                            begin
                                phase   <= cur_cmd.write ? PH_DATA_WRITE : PH_RESTART;
                                bit_cnt <= '0;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        PH_DATA_WRITE:
                            if (byte_done)
                            begin
                                phase   <= PH_STOP;
                                bit_cnt <= '0;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        PH_RESTART:
                        begin
                            phase   <= PH_CTRL_READ;
                            bit_cnt <= '0;
                        end
                        PH_CTRL_READ:
                            if (byte_done)
                            begin
                                phase   <= PH_DATA_READ;
                                bit_cnt <= '0;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        PH_DATA_READ:
                            if (bit_cnt == BIT_CNT_W'(ACK_BIT - 1))
                            begin
                                phase   <= PH_MASTER_NACK;
                                bit_cnt <= '0;
                            end
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        PH_MASTER_NACK:
                            phase <= PH_STOP;
                        default:
                            phase <= PH_IDLE; // end of stop
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (grant)
        begin
            cur_cmd    <= cmd;
            cur_client <= cmd_client;
        end
        if (phase == PH_DATA_READ && mid_high)
            rd_data <= {rd_data[6:0], sda_in};
        if (slot_end)
        begin
            case (phase)
                PH_START, PH_RESTART:
                    shreg <= ctrl;
                PH_CTRL_WRITE:
                    shreg <= byte_done ? cur_cmd.addr[WORD_W-1:0] : {shreg[6:0], 1'b0};
                PH_ADDR_WRITE:
                    shreg <= byte_done ? cur_cmd.data : {shreg[6:0], 1'b0};
                PH_DATA_WRITE, PH_CTRL_READ:
                    shreg <= {shreg[6:0], 1'b0}; // msb first
                default:
                    shreg <= shreg;
            endcase
        end
    end

    assign rsp_valid = (phase == PH_STOP) && slot_end;

    always_comb
    begin
        rsp.client = cur_client;
        rsp.write  = cur_cmd.write;
        rsp.addr   = cur_cmd.addr;
        rsp.data   = cur_cmd.write ? cur_cmd.data : rd_data;
    end

endmodule

// File: source/eeprom_top.sv
`timescale 1ns/1ps
module eeprom_top (
    input  logic                                     CLK,
    input  logic                                     RESET,
    input  logic [eeprom_req_pkg::NUM_CLIENTS-1:0]   req_valid,
    input  eeprom_req_pkg::eeprom_req_t              req [eeprom_req_pkg::NUM_CLIENTS],
    output logic [eeprom_req_pkg::NUM_CLIENTS-1:0]   credit_return,
    output logic                                     rsp_valid,
    output eeprom_req_pkg::eeprom_rsp_t              rsp,
    output logic                                     scl,
    output logic                                     sda_low,
    input  logic                                     sda_in
);
    import eeprom_req_pkg::*;

    // grant channel
    logic        cmd_valid;
    logic        cmd_ready;
    eeprom_req_t cmd;
    client_id_t  cmd_client;

    eeprom_arbiter u_arbiter (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_client    (cmd_client),
        .cmd_ready     (cmd_ready)
    );

    eeprom_serial_engine u_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_client (cmd_client),
        .cmd_ready  (cmd_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda_in)
    );

endmodule

// File: bench/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    output logic sda_low
);
    import eeprom_bus_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_WADDR, M_WDATA, M_SEND} model_state_t;

    logic [7:0]         mem [2**ADDR_W];
    model_state_t       state    = M_IDLE;
    logic               prev_scl = 1'b1;
    logic               prev_sda = 1'b1;
    int                 bit_cnt  = 0;   // scl rising edges in the current byte
    logic [7:0]         shift_in = '0;
    logic [7:0]         tx       = '0;
    logic [BLOCK_W-1:0] block    = '0;
    logic [ADDR_W-1:0]  addr     = '0;

    initial
    begin
        sda_low = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++)
            mem[a] = 8'hFF ^ a[7:0] ^ {a[10:8], 5'b0};
    end

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (prev_scl && scl && prev_sda && !sda)
        begin
            state   <= M_CTRL;   // start or repeated start
            bit_cnt <= 0;
        end
        else if (prev_scl && scl && !prev_sda && sda)
        begin
            state   <= M_IDLE;   // stop
            bit_cnt <= 0;
            sda_low <= 1'b0;
        end
        else if (!prev_scl && scl)
        begin
            if (state != M_SEND && bit_cnt < 8)
                shift_in <= {shift_in[6:0], sda};
            bit_cnt <= bit_cnt + 1;
        end
        else if (prev_scl && !scl)
        begin
            if (bit_cnt == 8)
            begin
                sda_low <= (state != M_SEND) && (state != M_IDLE); // ack
                case (state)
                    M_CTRL:
                        if (shift_in[7:4] != DEV_CODE)
                        begin
                            state   <= M_IDLE;
                            sda_low <= 1'b0;
                        end
                        else if (shift_in[0])
                        begin
                            state <= M_SEND;
                            tx    <= mem[addr];
                        end
                        else
                        begin
                            block <= shift_in[3:1];
                            state <= M_WADDR;
                        end
                    M_WADDR:
                    begin
                        addr  <= {block, shift_in};
                        state <= M_WDATA;
                    end
                    M_WDATA:
                    begin
                        mem[addr] <= shift_in;
                        state     <= M_IDLE;
                    end
                    default:
                        state <= M_IDLE; // master nack slot follows
                endcase
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt <= 0;
                sda_low <= (state == M_SEND) && !tx[7];
            end
            else if (state == M_SEND && bit_cnt > 0)
                sda_low <= !tx[7 - bit_cnt];
        end
    end

endmodule

// File: bench/eeprom_assert.sv
`timescale 1ns/1ps
module eeprom_assert (
    input logic                                     CLK,
    input logic                                     RESET,
    input logic [eeprom_req_pkg::NUM_CLIENTS-1:0]   req_valid,
    input logic [eeprom_req_pkg::CREDIT_W-1:0]      q_count [eeprom_req_pkg::NUM_CLIENTS],
    input logic                                     rsp_valid,
    input eeprom_bus_pkg::engine_phase_t            phase,
    input logic                                     scl,
    input logic                                     sda_low
);
    import eeprom_bus_pkg::*;
    import eeprom_req_pkg::*;

    for (genvar i = 0; i < NUM_CLIENTS; i++)
    begin : g_queue
        a_no_push_full: assert property (@(posedge CLK) disable iff (RESET)
            req_valid[i] |-> q_count[i] < CREDIT_W'(REQ_CREDITS))
            else $error("request pushed into a full queue");
    end

    a_rsp_pulse: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid high on two consecutive cycles");

    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        phase == PH_IDLE |-> scl && !sda_low)
        else $error("bus not released while engine idle");

endmodule

bind eeprom_top eeprom_assert u_assert (
    .CLK       (CLK),
    .RESET     (RESET),
    .req_valid (req_valid),
    .q_count   (u_arbiter.q_count),
    .rsp_valid (rsp_valid),
    .phase     (u_engine.phase),
    .scl       (scl),
    .sda_low   (sda_low)
);

// File: bench/eeprom_tb.sv
`timescale 1ns/1ps
module eeprom_tb;
    import eeprom_bus_pkg::*;
    import eeprom_req_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int MEM_BYTES      = 2**ADDR_W;

    logic                   CLK;
    logic                   RESET;
    logic [NUM_CLIENTS-1:0] req_valid;
    eeprom_req_t            req [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] credit_return;
    logic                   rsp_valid;
    eeprom_rsp_t            rsp;
    logic                   scl;
    logic                   sda_low;
    logic                   mem_sda_low;
    logic                   sda;

    logic [7:0]  shadow [MEM_BYTES];
    eeprom_req_t issued [NUM_CLIENTS][$];   // requests waiting for a response
    client_id_t  granted [$];               // clients in grant order
    int          credits [NUM_CLIENTS];
    int          errors = 0;
    int          checks = 0;
    int          rsp_count = 0;
    int          rsp_total = 0;
    bit          check_alternation = 1'b0;
    client_id_t  last_client = '0;

    assign sda = !(sda_low || mem_sda_low); // wired-AND, pulled up

    eeprom_top u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .scl           (scl),
        .sda_low       (sda_low),
        .sda_in        (sda)
    );

    eeprom_model u_mem (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda),
        .sda_low (mem_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [7:0] fill_byte(input int a);
        return 8'hFF ^ a[7:0] ^ {a[10:8], 5'b0};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int c = 0; c < NUM_CLIENTS; c++)
            n += issued[c].size();
        return n;
    endfunction

    task automatic finish_run();
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t: nothing happened for %0d cycles while waiting for %s",
                 $time, TIMEOUT_CYCLES, what);
        $display("checks %0d, errors %0d", checks, errors);
        finish_run();
    endtask

    task automatic compare_rsp(input eeprom_rsp_t got, input eeprom_rsp_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: rsp = %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_client(input client_id_t got, input client_id_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: rsp.client = %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_credit(input int c, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("** Error at %0t: credits[%0d] = %0d, expected %0d", $time, c, got, exp);
        end
    endtask

    // response and credit monitor, sampled mid-cycle
    always @(negedge CLK)
    begin
        eeprom_req_t head;
        eeprom_rsp_t exp;
        client_id_t  exp_client;
        if (rsp_valid)
        begin
            if (granted.size() == 0)
            begin
                errors++;
                $display("response at %0t with no request granted", $time);
            end
            else
            begin
                exp_client = granted.pop_front(); // one transfer at a time
                if (issued[exp_client].size() == 0)
                begin
                    errors++;
                    $display("response for client %0d at %0t with no request outstanding",
                             exp_client, $time);
                end
                else
                begin
                    head       = issued[exp_client].pop_front();
                    exp.client = exp_client;
                    exp.write  = head.write;
                    exp.addr   = head.addr;
                    exp.data   = head.write ? head.data : shadow[head.addr];
                    compare_rsp(rsp, exp);
                    if (head.write)
                        shadow[head.addr] = head.data;
                end
            end
            if (check_alternation && rsp_count > 0)
                compare_client(rsp.client, ~last_client);
            last_client = rsp.client;
            rsp_count++;
            rsp_total++;
        end
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            if (credit_return[c])
            begin
                credits[c]++;
                granted.push_back(client_id_t'(c));
                if (credits[c] > REQ_CREDITS)
                begin
                    errors++;
                    $display("client %0d got back more credits than it spent at %0t", c, $time);
                end
            end
        end
    end

    function automatic eeprom_req_t random_req();
        eeprom_req_t r;
        r.write = 1'($urandom_range(0, 1));
        if ($urandom_range(0, 1) == 1)
            r.addr = ADDR_W'($urandom_range(0, MEM_BYTES - 1));
        else
            r.addr = ADDR_W'($urandom_range(0, 15) * 128 + 5); // small set, reads hit writes
        r.data = 8'($urandom);
        return r;
    endfunction

    task automatic send_req(input int c, input eeprom_req_t r);
        int waited;
        waited = 0;
        while (credits[c] == 0)
        begin
            @(posedge CLK);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                report_timeout($sformatf("a credit for client %0d", c));
        end
        @(posedge CLK);
        #1;
        req_valid[c] = 1'b1;
        req[c]       = r;
        credits[c]--;
        issued[c].push_back(r);
        @(posedge CLK);
        #1;
        req_valid[c] = 1'b0;
    endtask

    task automatic run_client(input int c, input int n, input int max_gap);
        repeat (n)
        begin
            repeat ($urandom_range(0, max_gap))
                @(posedge CLK);
            send_req(c, random_req());
        end
    endtask

    task automatic wait_drain();
        int idle;
        int seen;
        idle = 0;
        seen = rsp_total;
        while (pending_count() != 0)
        begin
            @(posedge CLK);
            if (rsp_total != seen)
            begin
                seen = rsp_total;
                idle = 0;
            end
            else
                idle++;
            if (idle > TIMEOUT_CYCLES)
                report_timeout("outstanding responses");
        end
    endtask

    task automatic check_idle_bus(input string when);
        repeat (8)
        begin
            @(negedge CLK);
            checks++;
            if (!(scl === 1'b1 && sda === 1'b1 && rsp_valid === 1'b0))
            begin
                errors++;
                $display("** Error at %0t: {scl,sda,rsp_valid} = %b%b%b, expected 110 (%s)",
                         $time, scl, sda, rsp_valid, when);
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("test %0d %s: %s", num, name, (errors == errors_before) ? "pass" : "fail");
    endtask

    initial
    begin
        int          e0;
        eeprom_req_t r;
        void'($urandom(64897));
        RESET     = 1'b1;
        req_valid = '0;
        for (int c = 0; c < NUM_CLIENTS; c++)
        begin
            req[c]     = '0;
            credits[c] = REQ_CREDITS;
        end
        for (int a = 0; a < MEM_BYTES; a++)
            shadow[a] = fill_byte(a);
        repeat (2)
            @(posedge CLK);
        #1;
        RESET = 1'b0;

        e0 = errors;
        check_idle_bus("after reset");
        report_test(1, "idle bus after reset", e0);

        e0 = errors;
        r = random_req();
        r.write = 1'b1;
        send_req(0, r);
        wait_drain();
        r.write = 1'b0;
        send_req(0, r);
        wait_drain();
        report_test(2, "write then read", e0);

        e0 = errors;
        fork
            run_client(0, 40, 6);
            run_client(1, 40, 6);
        join
        wait_drain();
        report_test(3, "random mixed traffic", e0);

        e0 = errors;
        rsp_count = 0;
        check_alternation = 1'b1;
        fork
            run_client(0, 20, 0);
            run_client(1, 20, 0);
        join
        wait_drain();
        check_alternation = 1'b0;
        report_test(4, "round-robin fairness", e0);

        e0 = errors;
        for (int c = 0; c < NUM_CLIENTS; c++)
            compare_credit(c, credits[c], REQ_CREDITS);
        report_test(5, "credit conservation", e0);

        e0 = errors;
        check_idle_bus("after drain");
        report_test(6, "idle bus after drain", e0);

        $display("checks %0d, errors %0d", checks, errors);
        finish_run();
    end

endmodule

// File: tb.f
source/eeprom_bus_pkg.sv
source/eeprom_req_pkg.sv
source/eeprom_arbiter.sv
source/eeprom_serial_engine.sv
source/eeprom_top.sv
bench/eeprom_model.sv
bench/eeprom_assert.sv
bench/eeprom_tb.sv

// File: Makefile
TOP = eeprom_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o eeprom_sim
	./obj_dir/eeprom_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
